//--- project.f
common/vis_pkg.sv
correlator/antenna_sampler.sv
correlator/correlator_unit.sv
source/vis_prefetch.sv
source/vis_buffer.sv
source/axil_vis_port.sv
source/vis_top.sv
dv/tb_vis_top.sv

//--- Bender.yml
package:
  name: vis_subsystem

sources:
  - common/vis_pkg.sv
  - correlator/antenna_sampler.sv
  - correlator/correlator_unit.sv
  - source/vis_prefetch.sv
  - source/vis_buffer.sv
  - source/axil_vis_port.sv
  - source/vis_top.sv
  - target: test
    files:
      - dv/tb_vis_top.sv

//--- dv/tb_vis_top.sv
`timescale 1ns/10ps

module tb_vis_top
   import vis_pkg::*;
;

   localparam int HS_TO    = 50;    // cycles allowed for one AXI handshake
   localparam int FRAME_TO = 400;   // cycles allowed for one block plus prefetch

   logic                    clk_i;
   logic                    reset_i;
   logic [NUM_ANT-1:0][1:0] ant;
   logic [AXI_AW-1:0]       awaddr, araddr;
   logic                    awvalid, wvalid, bready, arvalid, rready;
   logic [AXI_DW-1:0]       wdata;
   logic [3:0]              wstrb;
   logic                    s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
   logic [1:0]              s_bresp_o, s_rresp_o;
   logic [AXI_DW-1:0]       s_rdata_o;
   logic                    ready_o;

   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   logic        timed_out = 1'b0;
   logic [31:0] rng = 32'h61af_0d83;

   vis_top dut (
      .clk_i, .reset_i, .ant_i(ant),
      .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o,
      .s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o,
      .s_bresp_o, .s_bvalid_o, .s_bready_i(bready),
      .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o,
      .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i(rready),
      .ready_o
   );

   always #50 clk_i = ~clk_i;   // 100 ns period

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // fresh random I/Q bits on every edge
   always @(posedge clk_i) begin
      rng <= xorshift32(rng);
      ant <= rng[2*NUM_ANT-1:0];
   end

   // ----------------------------
   // reference model
   // ----------------------------
   // evaluated at negedge, predicts what the next rising edge does
   logic             m_en;
   logic [BLEN_W-1:0] m_blen;      // block length register
   logic [BLEN_W-1:0] m_lat;       // length latched at block start
   int               m_cnt;
   int               m_eff;
   int               m_frames;
   logic [VIS_W-1:0] acc_re [NUM_CORR];
   logic [VIS_W-1:0] acc_im [NUM_CORR];
   logic [VIS_W-1:0] exp_vis [NUM_WORDS];   // last completed frame

   always @(negedge clk_i) begin
      if (reset_i) begin
         m_en     = 1'b0;
         m_blen   = DEF_BLOCK;
         m_lat    = DEF_BLOCK;
         m_cnt    = 0;
         m_frames = 0;
         for (int k = 0; k < NUM_CORR; k++) begin
            acc_re[k] = '0;
            acc_im[k] = '0;
         end
      end else begin
         if (m_en) begin
            m_eff = (m_cnt == 0) ? m_blen : m_lat;
            if (m_cnt == 0) m_lat = m_blen;
            for (int k = 0; k < NUM_CORR; k++) begin
               // real counts I==I, imag counts Q of a against I of b
               if (ant[PAIR_A[k]][BIT_I] == ant[PAIR_B[k]][BIT_I]) acc_re[k] = acc_re[k] + 1'b1;
               if (ant[PAIR_A[k]][BIT_Q] == ant[PAIR_B[k]][BIT_I]) acc_im[k] = acc_im[k] + 1'b1;
            end
            if (m_cnt == m_eff - 1) begin
               for (int k = 0; k < NUM_CORR; k++) begin
                  exp_vis[2*k]   = acc_re[k];
                  exp_vis[2*k+1] = acc_im[k];
                  acc_re[k]      = '0;
                  acc_im[k]      = '0;
               end
               m_cnt    = 0;
               m_frames = m_frames + 1;
            end else begin
               m_cnt = m_cnt + 1;
            end
         end
         // host write lands on the coming edge
         if (awvalid && wvalid && s_awready_o) begin
            case (awaddr)
               REG_CTRL: m_en = wdata[0];
               REG_BLEN: m_blen = (wdata[BLEN_W-1:0] < MIN_BLOCK) ? MIN_BLOCK : wdata[BLEN_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // ----------------------------
   // protocol assertions
   // ----------------------------
   assert property (@(posedge clk_i) disable iff (reset_i)
      (s_rvalid_o && !rready) |=> (s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o)))
      else begin
         errors++;
         $display("t=%0t read data changed or dropped while rready was low", $time);
      end

   assert property (@(posedge clk_i) disable iff (reset_i) s_rvalid_o |-> !s_arready_o)
      else begin
         errors++;
         $display("t=%0t arready high while a read response was pending", $time);
      end

   assert property (@(posedge clk_i) disable iff (reset_i) (m_frames == 0) |-> !ready_o)
      else begin
         errors++;
         $display("t=%0t ready_o rose before the first block ended", $time);
      end

   // ----------------------------
   // helpers
   // ----------------------------
   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      end
   endtask

   task automatic note_timeout(input string why);
      if (!timed_out) begin
         $display("t=%0t timeout, %s", $time, why);
         errors++;
      end
      timed_out = 1'b1;
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "pass" : "fail");
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int t;
      @(posedge clk_i);
      awaddr  <= addr;
      wdata   <= data;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      @(negedge clk_i);
      for (t = 0; !s_awready_o && t < HS_TO && !timed_out; t++) @(negedge clk_i);
      if (!s_awready_o) note_timeout("write address and data were never accepted");
      check_eq("s_wready_o", 32'(s_wready_o), 32'd1);   // W taken together with AW
      @(posedge clk_i);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      @(negedge clk_i);
      for (t = 0; !s_bvalid_o && t < HS_TO && !timed_out; t++) @(negedge clk_i);
      if (!s_bvalid_o) note_timeout("no write response");
      resp = s_bresp_o;
      @(posedge clk_i);
      bready <= 1'b1;
      @(posedge clk_i);
      bready <= 1'b0;
   endtask

   // hold keeps rready low for that many cycles after rvalid
   task automatic axi_read(input logic [7:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
      int t;
      int h;
      @(posedge clk_i);
      araddr  <= addr;
      arvalid <= 1'b1;
      @(negedge clk_i);
      for (t = 0; !s_arready_o && t < HS_TO && !timed_out; t++) @(negedge clk_i);
      if (!s_arready_o) note_timeout("read address was never accepted");
      @(posedge clk_i);
      arvalid <= 1'b0;
      @(negedge clk_i);
      for (t = 0; !s_rvalid_o && t < HS_TO && !timed_out; t++) @(negedge clk_i);
      if (!s_rvalid_o) note_timeout("read data never became valid");
      data = s_rdata_o;
      resp = s_rresp_o;
      for (h = 0; h < hold; h++) begin
         @(negedge clk_i);
         check_eq("s_rvalid_o", 32'(s_rvalid_o), 32'd1);
         check_eq("s_rdata_o", s_rdata_o, data);
         check_eq("s_arready_o", 32'(s_arready_o), 32'd0);
      end
      @(posedge clk_i);
      rready <= 1'b1;
      @(posedge clk_i);
      rready <= 1'b0;
   endtask

   // waits for a fresh frame, pauses sampling, then checks it all
   int last_frame = -1;

   task automatic check_frame();
      logic [31:0] d;
      logic [1:0]  r;
      logic [31:0] sum;
      int          w;
      int          t;
      @(negedge clk_i);
      for (t = 0; ready_o && t < FRAME_TO && !timed_out; t++) @(negedge clk_i);
      if (ready_o) note_timeout("ready_o was never cleared by a new block");
      for (t = 0; !ready_o && t < FRAME_TO && !timed_out; t++) @(negedge clk_i);
      if (!ready_o) note_timeout("ready_o did not rise after a block");
      axi_write(REG_CTRL, 32'd0, r);
      sum = '0;
      for (w = 0; w < NUM_WORDS; w++) begin
         axi_read(8'(REG_VIS_BASE + 4 * w), 0, d, r);
         check_eq($sformatf("vis[%0d]", w), d, 32'(exp_vis[w]));
         check_eq("s_rresp_o", 32'(r), 32'(RESP_OKAY));
         sum = sum + 32'(exp_vis[w]);
      end
      axi_read(REG_CHECK, 0, d, r);
      check_eq("checksum", d, sum);
      axi_read(REG_STATUS, 0, d, r);
      check_eq("status", d, {16'h0000, 8'(m_frames), 7'h00, 1'b1});
      if (last_frame >= 0) check_eq("frame step", 32'(d[15:8]), 32'(8'(last_frame + 1)));
      last_frame = d[15:8];
      axi_write(REG_CTRL, 32'd1, r);
   endtask

   // ----------------------------
   // test sequence
   // ----------------------------
   initial begin
      logic [31:0] d;
      logic [1:0]  r;
      int          e0;
      clk_i   = 1'b0;
      reset_i = 1'b1;
      ant     = '0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hF;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (8) @(posedge clk_i);
      reset_i <= 1'b0;

      e0 = errors;   // reset values
      axi_read(REG_BLEN, 0, d, r);
      check_eq("block_len", d, 32'(DEF_BLOCK));
      axi_read(REG_STATUS, 0, d, r);
      check_eq("status", d, 32'd0);
      check_eq("ready_o", 32'(ready_o), 32'd0);
      report_test("reset state", e0);

      e0 = errors;   // blocks of 40
      axi_write(REG_BLEN, 32'd40, r);
      check_eq("s_bresp_o", 32'(r), 32'(RESP_OKAY));
      axi_write(REG_CTRL, 32'd1, r);
      check_eq("s_bresp_o", 32'(r), 32'(RESP_OKAY));
      check_frame();
      check_frame();
      report_test("visibilities at block length 40", e0);

      e0 = errors;
      check_frame();
      report_test("checksum and frame count", e0);

      e0 = errors;   // clamp to the minimum
      axi_write(REG_BLEN, 32'd5, r);
      axi_read(REG_BLEN, 0, d, r);
      check_eq("block_len", d, 32'(MIN_BLOCK));
      check_frame();
      check_frame();
      report_test("block length clamp", e0);

      e0 = errors;
      axi_write(REG_CHECK, 32'h1234, r);
      check_eq("s_bresp_o", 32'(r), 32'(RESP_SLVERR));
      axi_read(8'h20, 0, d, r);
      check_eq("s_rresp_o", 32'(r), 32'(RESP_SLVERR));
      check_eq("s_rdata_o", d, 32'd0);
      axi_read(8'h70, 0, d, r);   // first word past the buffer
      check_eq("s_rresp_o", 32'(r), 32'(RESP_SLVERR));
      check_eq("s_rdata_o", d, 32'd0);
      report_test("error responses", e0);

      e0 = errors;   // host stalls the R channel
      axi_read(REG_BLEN, 6, d, r);
      check_eq("block_len", d, 32'(MIN_BLOCK));
      report_test("read back-pressure", e0);

      $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- source/vis_top.sv
`timescale 1ns/10ps

module vis_top
   import vis_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic [NUM_ANT-1:0][1:0] ant_i,
   // AXI4-Lite host port
   input  logic [AXI_AW-1:0]       s_awaddr_i,
   input  logic                    s_awvalid_i,
   output logic                    s_awready_o,
   input  logic [AXI_DW-1:0]       s_wdata_i,
   input  logic [3:0]              s_wstrb_i,
   input  logic                    s_wvalid_i,
   output logic                    s_wready_o,
   output logic [1:0]              s_bresp_o,
   output logic                    s_bvalid_o,
   input  logic                    s_bready_i,
   input  logic [AXI_AW-1:0]       s_araddr_i,
   input  logic                    s_arvalid_i,
   output logic                    s_arready_o,
   output logic [AXI_DW-1:0]       s_rdata_o,
   output logic [1:0]              s_rresp_o,
   output logic                    s_rvalid_o,
   input  logic                    s_rready_i,
   output logic                    ready_o     // visibility frame available
);

   logic [NUM_ANT-1:0][1:0]        ant_q;
   logic                           valid, swap, enable;
   logic [BLEN_W-1:0]              block_len;
   vis_part_e                      rd_part;
   logic [NUM_CORR-1:0][VIS_W-1:0] rd_data;
   logic                           wr_en;
   logic [WADDR_W-1:0]             wr_addr, buf_addr;
   logic [VIS_W-1:0]               wr_data, buf_data;
   logic [7:0]                     frame;
   logic [31:0]                    checksum;

   antenna_sampler u_sampler (
      .clk_i, .reset_i, .ant_i,
      .enable_i(enable), .block_len_i(block_len),
      .ant_o(ant_q), .valid_o(valid), .swap_o(swap)
   );

   // ----------------------------
   // one correlator per pair
   // ----------------------------
   for (genvar k = 0; k < NUM_CORR; k++) begin : g_corr
      correlator_unit u_corr (
         .clk_i, .reset_i,
         .ant_a_i(ant_q[PAIR_A[k]]), .ant_b_i(ant_q[PAIR_B[k]]),
         .valid_i(valid), .swap_i(swap),
         .rd_part_i(rd_part), .rd_data_o(rd_data[k])
      );
   end

   vis_prefetch u_prefetch (
      .clk_i, .reset_i, .swap_i(swap),
      .rd_part_o(rd_part), .rd_data_i(rd_data),
      .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
      .ready_o, .frame_o(frame), .checksum_o(checksum)
   );

   vis_buffer u_buffer (
      .clk_i, .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
      .rd_addr_i(buf_addr), .rd_data_o(buf_data)
   );

   axil_vis_port u_port (
      .clk_i, .reset_i,
      .s_awaddr_i, .s_awvalid_i, .s_awready_o, .s_wdata_i, .s_wstrb_i,
      .s_wvalid_i, .s_wready_o, .s_bresp_o, .s_bvalid_o, .s_bready_i,
      .s_araddr_i, .s_arvalid_i, .s_arready_o, .s_rdata_o, .s_rresp_o,
      .s_rvalid_o, .s_rready_i,
      .enable_o(enable), .block_len_o(block_len),
      .buf_addr_o(buf_addr), .buf_data_i(buf_data),
      .ready_i(ready_o), .frame_i(frame), .checksum_i(checksum)
   );

endmodule

//--- source/axil_vis_port.sv
`timescale 1ns/10ps

module axil_vis_port
   import vis_pkg::*;
(
   input  logic               clk_i,
   input  logic               reset_i,
   // AXI4-Lite slave
   input  logic [AXI_AW-1:0]  s_awaddr_i,
   input  logic               s_awvalid_i,
   output logic               s_awready_o,
   input  logic [AXI_DW-1:0]  s_wdata_i,
   input  logic [3:0]         s_wstrb_i,
   input  logic               s_wvalid_i,
   output logic               s_wready_o,
   output logic [1:0]         s_bresp_o,
   output logic               s_bvalid_o,
   input  logic               s_bready_i,
   input  logic [AXI_AW-1:0]  s_araddr_i,
   input  logic               s_arvalid_i,
   output logic               s_arready_o,
   output logic [AXI_DW-1:0]  s_rdata_o,
   output logic [1:0]         s_rresp_o,
   output logic               s_rvalid_o,
   input  logic               s_rready_i,
   // subsystem side
   output logic               enable_o,
   output logic [BLEN_W-1:0]  block_len_o,
   output logic [WADDR_W-1:0] buf_addr_o,
   input  logic [VIS_W-1:0]   buf_data_i,
   input  logic               ready_i,
   input  logic [7:0]         frame_i,
   input  logic [31:0]        checksum_i
);

   // ----------------------------
   // write channel
   // ----------------------------
   logic              wr_go;     // AW and W taken together
   logic [AXI_DW-1:0] cur_val;   // register value before the write
   logic [AXI_DW-1:0] wr_val;    // after byte strobes

   assign wr_go       = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
   assign s_awready_o = wr_go;   // low while B waits
   assign s_wready_o  = wr_go;

   always_comb begin
      cur_val = (s_awaddr_i == REG_BLEN) ? AXI_DW'(block_len_o) : AXI_DW'(enable_o);
      for (int b = 0; b < 4; b++) begin
         wr_val[8*b +: 8] = s_wstrb_i[b] ? s_wdata_i[8*b +: 8] : cur_val[8*b +: 8];
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         enable_o    <= 1'b0;
         block_len_o <= DEF_BLOCK;
         s_bvalid_o  <= 1'b0;
         s_bresp_o   <= RESP_OKAY;
      end else if (wr_go) begin
         s_bvalid_o <= 1'b1;
         s_bresp_o  <= RESP_OKAY;
         case (s_awaddr_i)
            REG_CTRL: enable_o <= wr_val[0];
            REG_BLEN: begin
               // clamp short blocks
               if (wr_val[BLEN_W-1:0] < MIN_BLOCK) begin
                  block_len_o <= MIN_BLOCK;
               end else begin
                  block_len_o <= wr_val[BLEN_W-1:0];
               end
            end
            default:  s_bresp_o <= RESP_SLVERR;  // read-only or unmapped
         endcase
      end else if (s_bready_i) begin
         s_bvalid_o <= 1'b0;
      end
   end

   // ----------------------------
   // read channel
   // ----------------------------
   logic [AXI_AW-1:0] ar_addr_q;
   logic              ar_v_q;     // address registered, buffer being read
   logic              buf_v_q;    // buffer data now valid
   logic [AXI_AW-1:0] vis_off;
   logic              vis_hit;
   logic [AXI_DW-1:0] rd_val;
   axil_resp_e        rd_resp;

   assign s_arready_o = !(ar_v_q || buf_v_q || s_rvalid_o);  // one read at a time
   assign vis_off     = ar_addr_q - REG_VIS_BASE;
   assign vis_hit     = (ar_addr_q >= REG_VIS_BASE) && (vis_off[1:0] == 2'b00)
                        && (vis_off < AXI_AW'(4 * NUM_WORDS));
   assign buf_addr_o  = vis_off[WADDR_W+1:2];

   // register / buffer decode
   always_comb begin
      rd_val  = '0;
      rd_resp = RESP_OKAY;
      if (vis_hit) begin
         rd_val = AXI_DW'(buf_data_i);  // zero-extended
      end else begin
         case (ar_addr_q)
            REG_CTRL:   rd_val = AXI_DW'(enable_o);
            REG_BLEN:   rd_val = AXI_DW'(block_len_o);
            REG_STATUS: rd_val = {16'h0000, frame_i, 7'b0000000, ready_i};
            REG_CHECK:  rd_val = checksum_i;
            default:    rd_resp = RESP_SLVERR;  // data stays zero
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (s_arvalid_i && s_arready_o) begin
         ar_addr_q <= s_araddr_i;
      end
      if (buf_v_q) begin
         s_rdata_o <= rd_val;  // held until rready
         s_rresp_o <= rd_resp;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ar_v_q     <= 1'b0;
         buf_v_q    <= 1'b0;
         s_rvalid_o <= 1'b0;
      end else begin
         ar_v_q  <= s_arvalid_i && s_arready_o;
         buf_v_q <= ar_v_q;
         if (buf_v_q) begin
            s_rvalid_o <= 1'b1;  // two cycles after AR
         end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
         end
      end
   end

endmodule

//--- source/vis_buffer.sv
`timescale 1ns/10ps

module vis_buffer
   import vis_pkg::*;
(
   input  logic               clk_i,
   // prefetcher side
   input  logic               wr_en_i,
   input  logic [WADDR_W-1:0] wr_addr_i,
   input  logic [VIS_W-1:0]   wr_data_i,
   // host side
   input  logic [WADDR_W-1:0] rd_addr_i,
   output logic [VIS_W-1:0]   rd_data_o
);

   // ----------------------------
   // storage
   // ----------------------------
   logic [VIS_W-1:0] mem [NUM_WORDS];  // one frame of visibilities

   // write port, filled after every swap
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read, one cycle latency
   // host decode keeps the address inside the frame
   always_ff @(posedge clk_i) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

//--- source/vis_prefetch.sv
`timescale 1ns/10ps

module vis_prefetch
   import vis_pkg::*;
(
   input  logic                           clk_i,
   input  logic                           reset_i,
   input  logic                           swap_i,
   output vis_part_e                      rd_part_o,   // broadcast to all correlators
   input  logic [NUM_CORR-1:0][VIS_W-1:0] rd_data_i,
   output logic                           wr_en_o,     // buffer write port
   output logic [WADDR_W-1:0]             wr_addr_o,
   output logic [VIS_W-1:0]               wr_data_o,
   output logic                           ready_o,     // frame complete in buffer
   output logic [7:0]                     frame_o,
   output logic [31:0]                    checksum_o
);

   prefetch_state_e      state_q;
   logic [WADDR_W-1:0]   idx_q;      // word being copied
   logic [WADDR_W-2:0]   corr_sel;   // correlator of that word
   logic                 last_word;

   // ----------------------------
   // word index decode
   // ----------------------------
   // word 2k real, 2k+1 imag of correlator k
   assign corr_sel  = idx_q[WADDR_W-1:1];
   assign rd_part_o = idx_q[0] ? VIS_IMAG : VIS_REAL;
   assign last_word = (idx_q == WADDR_W'(NUM_WORDS - 1));

   assign wr_en_o   = (state_q == PF_FETCH);  // one word per fetch cycle
   assign wr_addr_o = idx_q;
   assign wr_data_o = rd_data_i[corr_sel];

   // ----------------------------
   // copy sequencer
   // ----------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= PF_IDLE;
         idx_q      <= '0;
         ready_o    <= 1'b0;
         frame_o    <= '0;
         checksum_o <= '0;
      end else if (swap_i) begin
         // new frame, also restarts a fetch in progress
         state_q    <= PF_FETCH;
         idx_q      <= '0;
         ready_o    <= 1'b0;
         frame_o    <= frame_o + 1'b1;
         checksum_o <= '0;
      end else begin
         case (state_q)
            PF_FETCH: begin
               checksum_o <= checksum_o + 32'(wr_data_o);  // sum of copied words
               if (last_word) begin
                  state_q <= PF_DONE;
                  idx_q   <= '0;
               end else begin
                  idx_q <= idx_q + 1'b1;
               end
            end
            PF_DONE: begin
               ready_o <= 1'b1;      // buffer and checksum now complete
               state_q <= PF_IDLE;
            end
            default: begin
               state_q <= PF_IDLE;   // wait for the next swap
            end
         endcase
      end
   end

endmodule

//--- correlator/correlator_unit.sv
`timescale 1ns/10ps

module correlator_unit
   import vis_pkg::*;
(
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic [1:0]       ant_a_i,     // first antenna of the pair
   input  logic [1:0]       ant_b_i,     // second antenna of the pair
   input  logic             valid_i,
   input  logic             swap_i,
   input  vis_part_e        rd_part_i,   // real or imag from frozen bank
   output logic [VIS_W-1:0] rd_data_o
);

   // ----------------------------
   // double-buffered counters
   // ----------------------------
   logic [VIS_W-1:0] re_q [2];
   logic [VIS_W-1:0] im_q [2];
   logic             bank_q;     // index of the active bank
   logic             frz;        // index of the frozen bank
   logic             hit_re;
   logic             hit_im;

   assign frz = ~bank_q;

   // 1-bit correlation by equality of signs
   assign hit_re = valid_i && (ant_a_i[BIT_I] == ant_b_i[BIT_I]);  // I.I
   assign hit_im = valid_i && (ant_a_i[BIT_Q] == ant_b_i[BIT_I]);  // Q.I

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         bank_q <= 1'b0;
         re_q[0] <= '0;
         re_q[1] <= '0;
         im_q[0] <= '0;
         im_q[1] <= '0;
      end else begin
         // active bank takes the sample, also on the swap cycle
         if (hit_re) begin
            re_q[bank_q] <= re_q[bank_q] + 1'b1;
         end
         if (hit_im) begin
            im_q[bank_q] <= im_q[bank_q] + 1'b1;
         end

         // exchange banks, the one becoming active restarts from zero
         if (swap_i) begin
            bank_q    <= frz;
            re_q[frz] <= '0;
            im_q[frz] <= '0;
         end
      end
   end

   // ----------------------------
   // read port
   // ----------------------------
   // combinational, frozen bank is stable for a whole block
   always_comb begin
      if (rd_part_i == VIS_IMAG) begin
         rd_data_o = im_q[frz];
      end else begin
         rd_data_o = re_q[frz];
      end
   end

endmodule

//--- correlator/antenna_sampler.sv
`timescale 1ns/10ps

module antenna_sampler
   import vis_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic [NUM_ANT-1:0][1:0]       ant_i,        // raw I/Q pins
   input  logic                          enable_i,
   input  logic [BLEN_W-1:0]             block_len_i,
   output logic [NUM_ANT-1:0][1:0]       ant_o,        // registered antenna bus
   output logic                          valid_o,
   output logic                          swap_o        // last sample of a block
);

   // ----------------------------
   // block counter
   // ----------------------------
   logic [BLEN_W-1:0] cnt_q;       // samples taken in this block
   logic [BLEN_W-1:0] blen_q;      // length latched at block start
   logic [BLEN_W-1:0] blen_eff;    // length that applies to this sample
   logic              last;

   // a new length is picked up only on the first sample of a block
   assign blen_eff = (cnt_q == '0) ? block_len_i : blen_q;
   assign last     = (cnt_q == blen_eff - 1'b1);

   // antenna bits, payload only
   always_ff @(posedge clk_i) begin
      if (enable_i) begin
         ant_o <= ant_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q   <= '0;
         blen_q  <= DEF_BLOCK;
         valid_o <= 1'b0;
         swap_o  <= 1'b0;
      end else if (enable_i) begin
         valid_o <= 1'b1;
         if (cnt_q == '0) begin
            blen_q <= block_len_i;  // latch for the rest of the block
         end
         if (last) begin
            cnt_q  <= '0;           // next sample opens a new block
            swap_o <= 1'b1;         // rides with the last valid sample
         end else begin
            cnt_q  <= cnt_q + 1'b1;
            swap_o <= 1'b0;
         end
      end else begin
         // paused: count held, no swap, no clear
         valid_o <= 1'b0;
         swap_o  <= 1'b0;
      end
   end

endmodule

//--- common/vis_pkg.sv
package vis_pkg;

   // ----------------------------
   // array sizes
   // ----------------------------
   localparam int NUM_ANT   = 4;             // antennas, one I and one Q bit each
   localparam int NUM_CORR  = 6;             // one correlator per antenna pair
   localparam int VIS_W     = 16;            // accumulator width, wraps mod 2^16
   localparam int NUM_WORDS = NUM_CORR * 2;  // real + imag per pair
   localparam int WADDR_W   = 4;             // visibility buffer address
   localparam int BLEN_W    = 16;            // block length register

   // bit positions inside one antenna sample
   localparam int BIT_I = 0;
   localparam int BIT_Q = 1;

   // pair table, order 01 02 03 12 13 23
   localparam int PAIR_A [NUM_CORR] = '{0, 0, 0, 1, 1, 2};
   localparam int PAIR_B [NUM_CORR] = '{1, 2, 3, 2, 3, 3};

   // block length limits, in samples
   localparam logic [BLEN_W-1:0] MIN_BLOCK = 16'd32;
   localparam logic [BLEN_W-1:0] DEF_BLOCK = 16'd64;

   // ----------------------------
   // host register map
   // ----------------------------
   localparam int AXI_AW = 8;   // byte address width at the host port
   localparam int AXI_DW = 32;

   localparam logic [AXI_AW-1:0] REG_CTRL     = 8'h00;  // bit0 = sampling enable
   localparam logic [AXI_AW-1:0] REG_BLEN     = 8'h04;  // block length
   localparam logic [AXI_AW-1:0] REG_STATUS   = 8'h08;  // bit0 ready, 15:8 frame count
   localparam logic [AXI_AW-1:0] REG_CHECK    = 8'h0C;  // checksum of last frame
   localparam logic [AXI_AW-1:0] REG_VIS_BASE = 8'h40;  // word k at base + 4k

   // read select into a correlator's frozen bank
   typedef enum logic {
      VIS_REAL = 1'b0,
      VIS_IMAG = 1'b1
   } vis_part_e;

   typedef enum logic [1:0] {
      PF_IDLE  = 2'd0,
      PF_FETCH = 2'd1,
      PF_DONE  = 2'd2
   } prefetch_state_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axil_resp_e;

endpackage
